// File: vlog.f
rtl/replica_pkg.sv
rtl/replica_cfg_if.sv
rtl/replica_apb_regs.sv
rtl/replica_stage.sv
rtl/replica_chain.sv
rtl/replica_egress.sv
rtl/replica_top.sv
tests/replica_properties.sv
tests/tb_replica.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the replica testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_replica -f vlog.f -Mdir obj_dir \
    && ./obj_dir/Vtb_replica > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tests/tb_replica.sv
`timescale 1ns/1ps
`default_nettype none

module tb_replica
    import replica_pkg::*;
();

logic          clk;
logic          reset;
logic [11:0]   paddr;
logic          psel;
logic          penable;
logic          pwrite;
logic [31:0]   pwdata;
logic [31:0]   prdata;
logic          pready;
logic          pslverr;
logic          in_valid;
replica_word_t in_data;
logic          in_ready;
logic          out_valid;
replica_word_t out_data;
logic          out_ready;

// mirror of the DUT state, records in internal lane order
opt_t          tbl [8];
replica_word_t recs [8][2];
logic          arm [8];
logic          bank;
replica_word_t exp_q [$];
logic          bp_mode;
integer        seed;
integer        ready_seed;
int            errors;
int            checks;
logic [31:0]   rd;
logic          err;

replica_top #(.num_stages(8)) dut0 (.*);

always #10 clk = ~clk;

always @(posedge clk) begin
    #2;
    out_ready = bp_mode ? 1'($random(ready_seed)) : 1'b1;
end

function automatic replica_word_t reverse_lanes(input replica_word_t x);
    replica_word_t y;
    for (int i = 0; i < 8; i++) begin
        y[i] = x[7-i];
    end
    return y;
endfunction

// expected output for one input word, armed stages take their output into the write bank
function automatic replica_word_t ref_word(input replica_word_t x);
    replica_word_t w;
    lane_t         tmp;
    w = reverse_lanes(x);
    for (int s = 0; s < 8; s++) begin
        case (tbl[s].op)
            op_swap: begin
                tmp         = w[tbl[s].k];
                w[tbl[s].k] = w[tbl[s].l];
                w[tbl[s].l] = tmp;
            end
            op_load: w[tbl[s].k] = recs[s][bank][tbl[s].l];
            default: ;
        endcase
        if (arm[s]) begin
            recs[s][!bank] = w;
            arm[s]         = 1'b0;
        end
    end
    return reverse_lanes(w);
endfunction

task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
endtask

task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("test failed");
    $finish;
endtask

task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    int t;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    t = 0;
    while (!pready) begin
        @(posedge clk);
        #3;
        t++;
        if (t > 20) abort_run("APB slave never raised pready");
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic write_opt(input int s, input opt_t o);
    apb_access(1'b1, addr_opt_base + 12'(4 * s), {24'd0, o}, rd, err);
    tbl[s] = o;
    check_value(err, 1'b0, "pslverr on op entry write");
endtask

task automatic check_table();
    for (int s = 0; s < 8; s++) begin
        apb_access(1'b0, addr_opt_base + 12'(4 * s), 32'd0, rd, err);
        check_value(rd, {24'd0, tbl[s]}, "op entry readback");
    end
endtask

task automatic send_word(input replica_word_t w);
    int t;
    in_valid = 1'b1;
    in_data  = w;
    exp_q.push_back(ref_word(w));
    #1;
    t = 0;
    while (!in_ready) begin
        @(posedge clk);
        #3;
        t++;
        if (t > 100) abort_run("input word never accepted");
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
endtask

task automatic send_random();
    send_word({$random(seed), $random(seed)});
endtask

task automatic drain();
    int t;
    t = 0;
    while (exp_q.size() != 0) begin
        @(posedge clk);
        #2;
        t++;
        if (t > 1000) abort_run("pipeline did not drain");
    end
endtask

// compares each output transfer, sampled mid-cycle where everything is settled
always @(negedge clk) begin
    replica_word_t exp_w;
    if (!reset) begin
        check_value(in_ready, !out_valid || out_ready, "in_ready against advance rule");
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected output word %h at %0t ns with none expected", out_data, $time);
            end else begin
                exp_w = exp_q.pop_front();
                check_value(out_data, exp_w, "output word");
            end
        end
    end
end

initial begin
    int   errs0;
    int   lat;
    opt_t o;
    clk        = 1'b0;
    reset      = 1'b1;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b1;
    bp_mode    = 1'b0;
    seed       = 77535;
    ready_seed = 77535;
    errors     = 0;
    checks     = 0;
    bank       = 1'b0;
    for (int s = 0; s < 8; s++) begin
        tbl[s]     = '0;
        recs[s][0] = '0;
        recs[s][1] = '0;
        arm[s]     = 1'b0;
    end
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    errs0 = errors;
    send_random();
    // counted up to the edge that first samples out_valid high
    lat = 1;
    while (!out_valid) begin
        @(posedge clk);
        #2;
        lat++;
        if (lat > 50) abort_run("first word never reached the output");
    end
    check_value(lat, 10, "first word latency");
    repeat (49) send_random();
    drain();
    $display("test 1 pass-through finished with %0d errors", errors - errs0);

    errs0 = errors;
    for (int s = 0; s < 8; s++) begin
        o.op = op_swap;
        o.k  = 3'($random(seed));
        // stage 0 swaps a lane with itself
        o.l  = (s == 0) ? o.k : 3'($random(seed));
        write_opt(s, o);
    end
    check_table();
    repeat (40) send_random();
    drain();
    $display("test 2 swaps finished with %0d errors", errors - errs0);

    errs0 = errors;
    apb_access(1'b1, addr_ctrl, 32'(cmd_capture), rd, err);
    for (int s = 0; s < 8; s++) begin
        arm[s] = 1'b1;
    end
    apb_access(1'b0, addr_status, 32'd0, rd, err);
    check_value(rd[1], 1'b0, "capture_done while armed");
    send_random();
    drain();
    apb_access(1'b0, addr_status, 32'd0, rd, err);
    check_value(rd[1:0], 2'b10, "status after capture");
    apb_access(1'b1, addr_ctrl, 32'(cmd_flip), rd, err);
    bank = ~bank;
    apb_access(1'b0, addr_status, 32'd0, rd, err);
    check_value(rd[0], 1'b1, "rbank after flip");
    for (int s = 0; s < 8; s++) begin
        o.op = op_load;
        o.k  = 3'($random(seed));
        o.l  = 3'($random(seed));
        write_opt(s, o);
    end
    repeat (30) send_random();
    drain();
    $display("test 3 capture and load finished with %0d errors", errors - errs0);

    errs0   = errors;
    bp_mode = 1'b1;
    repeat (60) send_random();
    drain();
    bp_mode = 1'b0;
    $display("test 4 back-pressure finished with %0d errors", errors - errs0);

    errs0 = errors;
    apb_access(1'b1, addr_opt_base + 12'd32, 32'h55, rd, err);
    check_value(err, 1'b1, "pslverr on stage 8 write");
    apb_access(1'b1, addr_opt_base + 12'h07c, 32'h55, rd, err);
    check_value(err, 1'b1, "pslverr on stage 31 write");
    apb_access(1'b0, addr_opt_base + 12'd32, 32'd0, rd, err);
    check_value(err, 1'b1, "pslverr on stage 8 read");
    apb_access(1'b1, addr_status, 32'h3, rd, err);
    check_value(err, 1'b1, "pslverr on status write");
    apb_access(1'b0, addr_status, 32'd0, rd, err);
    check_value(rd[0], bank, "rbank after status write");
    check_table();
    $display("test 5 APB errors finished with %0d errors", errors - errs0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display("test passed");
    end else begin
        $display("test failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: tests/replica_properties.sv
`timescale 1ns/1ps
`default_nettype none

module replica_properties
    import replica_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          advance,
    input  logic          chain_valid,
    input  replica_word_t chain_data,
    input  logic          out_valid,
    input  replica_word_t out_data,
    input  logic          out_ready
);

// a stalled word stays in place until it is taken
property held_while_stalled;
    @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data));
endproperty

assert property (held_while_stalled)
    else $error("output word changed while stalled");

// with advance low the chain keeps its last word waiting for the egress
assert property (@(posedge clk) disable iff (reset)
    (chain_valid && !advance) |=> (chain_valid && $stable(chain_data)))
    else $error("chain word moved while advance was low");

assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high after reset");

endmodule

bind replica_egress replica_properties props0 (
    .clk         (clk),
    .reset       (reset),
    .advance     (advance),
    .chain_valid (chain_valid),
    .chain_data  (chain_data),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_ready   (out_ready)
);

`default_nettype wire

// File: rtl/replica_top.sv
`timescale 1ns/1ps
`default_nettype none

module replica_top
    import replica_pkg::*;
#(
    parameter int num_stages = 8
)(
    input  logic          clk,
    input  logic          reset,
    input  logic [11:0]   paddr,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [31:0]   pwdata,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr,
    input  logic          in_valid,
    input  replica_word_t in_data,
    output logic          in_ready,
    output logic          out_valid,
    output replica_word_t out_data,
    input  logic          out_ready
);

logic          advance;
logic          chain_valid;
replica_word_t chain_data;

replica_cfg_if #(.num_stages(num_stages)) cfg_if ();

replica_apb_regs #(.num_stages(num_stages)) u_regs (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cfg     (cfg_if.regs)
);

replica_chain #(.num_stages(num_stages)) u_chain (
    .clk         (clk),
    .reset       (reset),
    .advance     (advance),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .cfg         (cfg_if.chain),
    .chain_valid (chain_valid),
    .chain_data  (chain_data)
);

replica_egress u_egress (
    .clk         (clk),
    .reset       (reset),
    .chain_valid (chain_valid),
    .chain_data  (chain_data),
    .out_ready   (out_ready),
    .advance     (advance),
    .out_valid   (out_valid),
    .out_data    (out_data)
);

assign in_ready = advance;

endmodule

`default_nettype wire

// File: rtl/replica_egress.sv
`timescale 1ns/1ps
`default_nettype none

module replica_egress
    import replica_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          chain_valid,
    input  replica_word_t chain_data,
    input  logic          out_ready,
    output logic          advance,
    output logic          out_valid,
    output replica_word_t out_data
);

// the whole chain moves only when the output slot is free or draining
assign advance = ~out_valid | out_ready;

always_ff @(posedge clk) begin
    if (reset) begin
        out_valid <= 1'b0;
    end else if (advance) begin
        out_valid <= chain_valid;
    end
end

// back to external lane order
always_ff @(posedge clk) begin
    if (advance) begin
        for (int i = 0; i < 8; i++) begin
            out_data[i] <= chain_data[7-i];
        end
    end
end

endmodule

`default_nettype wire

// File: rtl/replica_chain.sv
`timescale 1ns/1ps
`default_nettype none

module replica_chain
    import replica_pkg::*;
#(
    parameter int num_stages = 8
)(
    input  logic          clk,
    input  logic          reset,
    input  logic          advance,
    input  logic          in_valid,
    input  replica_word_t in_data,
    replica_cfg_if.chain  cfg,
    output logic          chain_valid,
    output replica_word_t chain_data
);

// index 0 is the head register, index s+1 is the output of stage s
logic          [num_stages:0]   link_valid;
replica_word_t [num_stages:0]   link_data;
logic          [num_stages-1:0] armed;

always_ff @(posedge clk) begin
    if (reset) begin
        link_valid[0] <= 1'b0;
    end else if (advance) begin
        link_valid[0] <= in_valid;
    end
end

// external lane i becomes internal lane 7-i
always_ff @(posedge clk) begin
    if (advance) begin
        for (int i = 0; i < 8; i++) begin
            link_data[0][i] <= in_data[7-i];
        end
    end
end

for (genvar g = 0; g < num_stages; g++) begin : g_stage
    replica_stage u_stage (
        .clk        (clk),
        .reset      (reset),
        .advance    (advance),
        .opt        (cfg.opt[g]),
        .rbank      (cfg.rbank),
        .capture    (cfg.capture),
        .prev_valid (link_valid[g]),
        .prev_data  (link_data[g]),
        .armed      (armed[g]),
        .out_valid  (link_valid[g+1]),
        .out_data   (link_data[g+1])
    );
end

assign cfg.capture_done = ~|armed;

assign chain_valid = link_valid[num_stages];
assign chain_data  = link_data[num_stages];

endmodule

`default_nettype wire

// File: rtl/replica_stage.sv
`timescale 1ns/1ps
`default_nettype none

module replica_stage
    import replica_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          advance,
    input  opt_t          opt,
    input  logic          rbank,
    input  logic          capture,
    input  logic          prev_valid,
    input  replica_word_t prev_data,
    output logic          armed,
    output logic          out_valid,
    output replica_word_t out_data
);

// two banks, the chain reads rbank and capture writes the other
replica_word_t rec [2];
replica_word_t next_data;

always_comb begin
    next_data = prev_data;
    case (opt.op)
        op_swap: begin
            next_data[opt.k] = prev_data[opt.l];
            next_data[opt.l] = prev_data[opt.k];
        end
        op_load: begin
            next_data[opt.k] = rec[rbank][opt.l];
        end
        default: ;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        out_valid <= 1'b0;
    end else if (advance) begin
        out_valid <= prev_valid;
    end
end

always_ff @(posedge clk) begin
    if (advance) begin
        out_data <= next_data;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        armed  <= 1'b0;
        rec[0] <= '0;
        rec[1] <= '0;
    end else begin
        // store the word leaving this stage
        if (armed && out_valid && advance) begin
            rec[~rbank] <= out_data;
            armed       <= 1'b0;
        end
        if (capture) begin
            armed <= 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// File: rtl/replica_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module replica_apb_regs
    import replica_pkg::*;
#(
    parameter int num_stages = 8
)(
    input  logic        clk,
    input  logic        reset,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    replica_cfg_if.regs cfg
);

localparam int idx_w = $clog2(max_stages);

logic             access;
logic [11:0]      opt_offset;
logic             opt_sel;
logic [idx_w-1:0] opt_idx;
logic             opt_hit;
apb_word_t        wword;
apb_word_t        rword;

assign access     = psel & penable;
assign opt_offset = paddr - addr_opt_base;
assign opt_sel    = (paddr >= addr_opt_base) &&
                    (paddr < addr_opt_base + 12'(4 * max_stages));
assign opt_idx    = opt_offset[idx_w+1:2];
// the window covers max_stages entries, only the first num_stages exist
assign opt_hit    = opt_sel && (opt_idx < num_stages);

assign wword = pwdata;

always_ff @(posedge clk) begin
    if (reset) begin
        cfg.rbank   <= 1'b0;
        cfg.capture <= 1'b0;
        cfg.opt     <= '0;
    end else begin
        cfg.capture <= 1'b0;
        if (access && pwrite) begin
            if (paddr == addr_ctrl) begin
                case (wword.ctrl.cmd)
                    cmd_capture: cfg.capture <= 1'b1;
                    cmd_flip:    cfg.rbank   <= ~cfg.rbank;
                    default: ;
                endcase
            end
            if (opt_hit) begin
                for (int s = 0; s < num_stages; s++) begin
                    if (opt_idx == idx_w'(s)) begin
                        cfg.opt[s] <= wword.op.opt;
                    end
                end
            end
        end
    end
end

// op entry readback through the op view
always_comb begin
    rword = '0;
    for (int s = 0; s < num_stages; s++) begin
        if (opt_idx == idx_w'(s)) begin
            rword.op.opt = cfg.opt[s];
        end
    end
end

always_comb begin
    prdata = '0;
    if (opt_hit) begin
        prdata = rword;
    end else if (paddr == addr_status) begin
        prdata = {30'd0, cfg.capture_done, cfg.rbank};
    end
end

// every access finishes in its access phase
assign pready  = 1'b1;
assign pslverr = access && ((opt_sel && !opt_hit) || (pwrite && paddr == addr_status));

endmodule

`default_nettype wire

// File: rtl/replica_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface replica_cfg_if
    import replica_pkg::*;
#(
    parameter int num_stages = 8
);

    opt_t [num_stages-1:0] opt;
    logic                  rbank;
    // single cycle, arms every stage
    logic                  capture;
    logic                  capture_done;

    modport regs (
        output opt,
        output rbank,
        output capture,
        input  capture_done
    );

    modport chain (
        input  opt,
        input  rbank,
        input  capture,
        output capture_done
    );

endinterface

`default_nettype wire

// File: rtl/replica_pkg.sv
`default_nettype none

package replica_pkg;

    typedef logic [7:0] lane_t;

    // lane 0 is the least significant byte
    typedef lane_t [7:0] replica_word_t;

    typedef enum logic [1:0] {
        op_pass = 2'd0,
        op_swap = 2'd1,
        op_load = 2'd2
    } op_code_t;

    typedef struct packed {
        op_code_t   op;
        logic [2:0] k;
        logic [2:0] l;
    } opt_t;

    typedef enum logic [1:0] {
        cmd_none    = 2'd0,
        cmd_capture = 2'd1,
        cmd_flip    = 2'd2
    } replica_cmd_t;

    // one apb data word, read as a command or as an op entry depending on address
    typedef union packed {
        struct packed {
            logic [29:0]  rsvd;
            replica_cmd_t cmd;
        } ctrl;
        struct packed {
            logic [23:0] rsvd;
            opt_t        opt;
        } op;
    } apb_word_t;

    localparam logic [11:0] addr_ctrl     = 12'h000;
    localparam logic [11:0] addr_status   = 12'h004;
    localparam logic [11:0] addr_opt_base = 12'h100;
    localparam int          max_stages    = 32;

endpackage

`default_nettype wire
